/* verilog/frame_pkg.sv */
/*
 * Shared constants for the SPI control path
 *   SPI byte width
 *   Subperipheral addresses and chip ID value
 *   Graphics command queue sizing
 */

package frame_pkg;

    // SPI framing
    localparam int byte_width = 8;

    // Chip ID register
    localparam logic [byte_width-1:0] chip_id_address = 8'hDB;
    localparam logic [byte_width-1:0] chip_id_value = 8'h81;

    // Graphics queue status byte, overflow in bit 7
    localparam logic [byte_width-1:0] graphics_status_address = 8'h0E;

    // Opcodes 0x10 to 0x1F are queued as commands
    localparam logic [byte_width-1:0] graphics_command_base = 8'h10;

    // Queue sizing, count must hold the full depth
    localparam int graphics_queue_depth = 8;
    localparam int graphics_count_width = 4;

endpackage

/* verilog/subperipheral_if.sv */
/*
 * Subperipheral bus between the SPI peripheral, the address selector
 * and the blocks it addresses
 */

interface subperipheral_if
    import frame_pkg::*;
();

    logic [byte_width-1:0] address;   // First byte of the transaction
    logic address_valid;              // Level, high until select rises
    logic [byte_width-1:0] copi;
    logic copi_valid;                 // One cycle per data byte
    logic [byte_width-1:0] cipo;      // Response for the next byte
    logic cipo_valid;

    modport peripheral (
        output address, address_valid, copi, copi_valid,
        input cipo, cipo_valid
    );

    modport selector (
        input address, address_valid,
        output cipo, cipo_valid
    );

    modport subperipheral (
        input address, address_valid, copi, copi_valid
    );

endinterface

/* verilog/spi_peripheral.sv */
/*
 * SPI mode 0 peripheral, oversampled by the system clock
 *   Two-flop pin synchronizers and SPI clock edge detection
 *   Address and data byte framing, MSB first
 *   Response shift register loaded at the start of each byte
 */

module spi_peripheral
    import frame_pkg::*;
(
    input logic clock_18MHz_oscillator,
    input logic reset,

    input logic spi_select,
    input logic spi_clock,
    input logic spi_data_in,
    output logic spi_data_out,

    subperipheral_if.peripheral bus
);

logic [1:0] select_sync;
logic [1:0] clock_sync;
logic [1:0] data_sync;
logic clock_previous;

logic select_active;
logic clock_rising;
logic clock_falling;

logic [$clog2(byte_width)-1:0] bit_count;
logic address_pending;              // Next complete byte is the address
logic [byte_width-2:0] copi_shift;
logic [byte_width-1:0] copi_byte;
logic [byte_width-1:0] cipo_shift;

// Pin synchronizers
always_ff @(posedge clock_18MHz_oscillator) begin
    if (reset) begin
        select_sync <= 2'b11;       // Deselected
        clock_sync <= 2'b00;
        clock_previous <= 1'b0;
    end else begin
        select_sync <= {select_sync[0], spi_select};
        clock_sync <= {clock_sync[0], spi_clock};
        clock_previous <= clock_sync[1];
    end
end

always_ff @(posedge clock_18MHz_oscillator) begin
    data_sync <= {data_sync[0], spi_data_in}; // Same delay as the clock
end

assign select_active = ~select_sync[1];
assign clock_rising = clock_sync[1] & ~clock_previous;
assign clock_falling = ~clock_sync[1] & clock_previous;

assign copi_byte = {copi_shift, data_sync[1]};

// Byte framing
always_ff @(posedge clock_18MHz_oscillator) begin
    if (reset) begin
        bit_count <= '0;
        address_pending <= 1'b1;
        bus.address_valid <= 1'b0;
        bus.copi_valid <= 1'b0;
    end else begin
        bus.copi_valid <= 1'b0;

        if (!select_active) begin
            bit_count <= '0;
            address_pending <= 1'b1;
            bus.address_valid <= 1'b0;
        end else if (clock_rising) begin
            bit_count <= bit_count + 1'b1;

            if (bit_count == '1) begin
                address_pending <= 1'b0;
                if (address_pending) begin
                    bus.address_valid <= 1'b1;
                end else begin
                    bus.copi_valid <= 1'b1;
                end
            end
        end
    end
end

// Received data
always_ff @(posedge clock_18MHz_oscillator) begin
    if (select_active && clock_rising) begin
        copi_shift <= copi_byte[byte_width-2:0];

        if (bit_count == '1) begin
            if (address_pending) begin
                bus.address <= copi_byte;
            end else begin
                bus.copi <= copi_byte;
            end
        end
    end
end

// Response shifter, changes on falling edges
always_ff @(posedge clock_18MHz_oscillator) begin
    if (reset) begin
        cipo_shift <= '0;
    end else if (!select_active) begin
        cipo_shift <= '0;
    end else if (clock_falling) begin
        if (bit_count == '0) begin
            // Start of a byte, take whatever the addressed block holds
            cipo_shift <= bus.cipo_valid ? bus.cipo : '0;
        end else begin
            cipo_shift <= {cipo_shift[byte_width-2:0], 1'b0};
        end
    end
end

assign spi_data_out = cipo_shift[byte_width-1];

// Data strobes only come out of a selected transaction
copi_valid_only_when_selected : assert property (
    @(posedge clock_18MHz_oscillator) disable iff (reset)
    bus.copi_valid |-> select_active
);

endmodule

/* verilog/spi_subperipheral_selector.sv */
/*
 * Subperipheral address decoder
 *   One-hot enables for chip ID, graphics commands and graphics status
 *   Response mux back to the SPI peripheral
 */

module spi_subperipheral_selector
    import frame_pkg::*;
(
    subperipheral_if.selector bus,

    output logic chip_id_enable,
    output logic graphics_command_enable,
    output logic graphics_status_enable,

    input logic [byte_width-1:0] chip_id_cipo,
    input logic chip_id_cipo_valid,
    input logic [byte_width-1:0] graphics_cipo,
    input logic graphics_cipo_valid
);

always_comb begin
    chip_id_enable = bus.address_valid && (bus.address == chip_id_address);

    // Whole upper nibble block of opcodes
    graphics_command_enable = bus.address_valid &&
        (bus.address[byte_width-1:4] == graphics_command_base[byte_width-1:4]);

    graphics_status_enable = bus.address_valid &&
        (bus.address == graphics_status_address);
end

always_comb begin
    bus.cipo = '0;
    bus.cipo_valid = 1'b0;                // Unmapped addresses stay silent

    if (chip_id_enable) begin
        bus.cipo = chip_id_cipo;
        bus.cipo_valid = chip_id_cipo_valid;
    end else if (graphics_command_enable || graphics_status_enable) begin
        bus.cipo = graphics_cipo;
        bus.cipo_valid = graphics_cipo_valid;
    end
end

endmodule

/* verilog/spi_register_chip_id.sv */
/*
 * Read-only chip ID register on the subperipheral bus
 */

module spi_register_chip_id
    import frame_pkg::*;
(
    input logic clock_18MHz_oscillator,
    input logic reset,

    input logic enable,
    output logic [byte_width-1:0] data,
    output logic data_valid
);

always_ff @(posedge clock_18MHz_oscillator) begin
    if (reset) begin
        data <= '0;
        data_valid <= 1'b0;
    end else if (enable) begin
        data <= chip_id_value;
        data_valid <= 1'b1;
    end else begin
        data <= '0;                     // Idle bus reads as zero
        data_valid <= 1'b0;
    end
end

endmodule

/* verilog/graphics_command_queue.sv */
/*
 * Graphics command queue
 *   FIFO of opcode and operand pairs with a valid/ready output stream
 *   Sticky overflow when a write meets a full queue
 *   Status byte with overflow and fill count
 */

module graphics_command_queue
    import frame_pkg::*;
(
    input logic clock_18MHz_oscillator,
    input logic reset,

    subperipheral_if.subperipheral bus,
    input logic command_enable,
    input logic status_enable,
    output logic [byte_width-1:0] status_data,
    output logic status_valid,

    output logic [byte_width-1:0] command_opcode,
    output logic [byte_width-1:0] command_operand,
    output logic command_valid,
    input logic command_ready
);

logic [2*byte_width-1:0] entries [graphics_queue_depth];
logic [$clog2(graphics_queue_depth)-1:0] write_pointer;
logic [$clog2(graphics_queue_depth)-1:0] read_pointer;
logic [graphics_count_width-1:0] count;
logic overflow;

logic full;
logic push_request;
logic push;
logic pop;

assign full = (count == graphics_count_width'(graphics_queue_depth));
assign push_request = command_enable && bus.copi_valid;
assign push = push_request && !full;          // Full queue drops the write
assign command_valid = (count != '0);
assign pop = command_valid && command_ready;

assign {command_opcode, command_operand} = entries[read_pointer];

always_ff @(posedge clock_18MHz_oscillator) begin
    if (push) begin
        entries[write_pointer] <= {bus.address, bus.copi};
    end
end

always_ff @(posedge clock_18MHz_oscillator) begin
    if (reset) begin
        write_pointer <= '0;
        read_pointer <= '0;
        count <= '0;
        overflow <= 1'b0;
    end else begin
        if (push) write_pointer <= write_pointer + 1'b1;  // Wraps at the depth
        if (pop) read_pointer <= read_pointer + 1'b1;

        count <= count + graphics_count_width'(push) - graphics_count_width'(pop);

        if (push_request && full) begin
            overflow <= 1'b1;                 // Held until reset
        end
    end
end

// Status byte
always_ff @(posedge clock_18MHz_oscillator) begin
    if (reset) begin
        status_data <= '0;
        status_valid <= 1'b0;
    end else if (status_enable) begin
        status_data <= {overflow, {(byte_width-1-graphics_count_width){1'b0}}, count};
        status_valid <= 1'b1;
    end else begin
        status_data <= '0;
        status_valid <= 1'b0;
    end
end

count_within_depth : assert property (
    @(posedge clock_18MHz_oscillator) disable iff (reset)
    count <= graphics_count_width'(graphics_queue_depth)
);

// Stalled entry must not change under the consumer
output_held_while_stalled : assert property (
    @(posedge clock_18MHz_oscillator) disable iff (reset)
    command_valid && !command_ready |=>
        command_valid && $stable(command_opcode) && $stable(command_operand)
);

endmodule

/* verilog/frame_top.sv */
/*
 * SPI control path top level
 *   SPI peripheral, address selector, chip ID register
 *   Graphics command queue with its output stream
 */

module frame_top
    import frame_pkg::*;
(
    input logic clock_18MHz_oscillator,
    input logic reset,

    input logic spi_select,
    input logic spi_clock,
    input logic spi_data_in,
    output logic spi_data_out,

    output logic [byte_width-1:0] command_opcode,
    output logic [byte_width-1:0] command_operand,
    output logic command_valid,
    input logic command_ready
);

subperipheral_if subperipheral_bus ();

logic chip_id_enable;
logic [byte_width-1:0] chip_id_cipo;
logic chip_id_cipo_valid;

logic graphics_command_enable;
logic graphics_status_enable;
logic [byte_width-1:0] graphics_cipo;
logic graphics_cipo_valid;

spi_peripheral spi_peripheral (
    .clock_18MHz_oscillator(clock_18MHz_oscillator),
    .reset(reset),
    .spi_select(spi_select),
    .spi_clock(spi_clock),
    .spi_data_in(spi_data_in),
    .spi_data_out(spi_data_out),
    .bus(subperipheral_bus.peripheral)
);

spi_subperipheral_selector spi_subperipheral_selector (
    .bus(subperipheral_bus.selector),
    .chip_id_enable(chip_id_enable),
    .graphics_command_enable(graphics_command_enable),
    .graphics_status_enable(graphics_status_enable),
    .chip_id_cipo(chip_id_cipo),
    .chip_id_cipo_valid(chip_id_cipo_valid),
    .graphics_cipo(graphics_cipo),
    .graphics_cipo_valid(graphics_cipo_valid)
);

spi_register_chip_id spi_register_chip_id (
    .clock_18MHz_oscillator(clock_18MHz_oscillator),
    .reset(reset),
    .enable(chip_id_enable),
    .data(chip_id_cipo),
    .data_valid(chip_id_cipo_valid)
);

graphics_command_queue graphics_command_queue (
    .clock_18MHz_oscillator(clock_18MHz_oscillator),
    .reset(reset),
    .bus(subperipheral_bus.subperipheral),
    .command_enable(graphics_command_enable),
    .status_enable(graphics_status_enable),
    .status_data(graphics_cipo),
    .status_valid(graphics_cipo_valid),
    .command_opcode(command_opcode),
    .command_operand(command_operand),
    .command_valid(command_valid),
    .command_ready(command_ready)
);

endmodule

/* dv/frame_tb.sv */
/*
 * Testbench for the SPI control path
 *   SPI mode 0 host running at a tenth of the system clock
 *   Command queue model with fill count and sticky overflow
 *   Stream monitor, random back-pressure and watchdog
 */

module frame_tb
    import frame_pkg::*;
();

timeunit 1ns;
timeprecision 100ps;

localparam int clock_period = 8;
localparam int spi_half_period = 5;         // System cycles per SPI half period
localparam int max_data_bytes = 12;
localparam int total_transactions = 32;
localparam int max_transaction_cycles = (max_data_bytes + 1) * 16 * spi_half_period
    + 6 * spi_half_period;
localparam longint timeout_ns = longint'(total_transactions) * max_transaction_cycles
    * clock_period + 20000;

logic clock_18MHz_oscillator;
logic reset;
logic spi_select;
logic spi_clock;
logic spi_data_in;
logic spi_data_out;
logic [7:0] command_opcode;
logic [7:0] command_operand;
logic command_valid;
logic command_ready;

integer random_seed;
integer ready_seed;
int ready_mode;                              // 0 low, 1 high, 2 random
logic [15:0] expected_entries[$];
logic [15:0] popped_entry;
logic [7:0] rx_bytes[$];
bit model_overflow;
int transfer_count;
int value_errors;
int other_errors;

frame_top i_frame_top (
    .clock_18MHz_oscillator(clock_18MHz_oscillator),
    .reset(reset),
    .spi_select(spi_select),
    .spi_clock(spi_clock),
    .spi_data_in(spi_data_in),
    .spi_data_out(spi_data_out),
    .command_opcode(command_opcode),
    .command_operand(command_operand),
    .command_valid(command_valid),
    .command_ready(command_ready)
);

initial begin
    clock_18MHz_oscillator = 1'b0;
    forever #(clock_period / 2) clock_18MHz_oscillator = ~clock_18MHz_oscillator;
end

initial begin
    #(timeout_ns);
    $display("Timeout: run did not finish within %0d ns", timeout_ns);
    $display("Test failed");
    $finish;
end

// Back-pressure driver, sole writer of command_ready
always @(posedge clock_18MHz_oscillator) begin
    #1;
    if (ready_mode == 2) command_ready = $random(ready_seed) & 1;
    else command_ready = (ready_mode == 1);
end

// Transfers take effect on the next rising edge
always @(negedge clock_18MHz_oscillator) begin
    if (!reset && command_valid && command_ready) begin
        transfer_count++;
        if (expected_entries.size() == 0) begin
            $display("Unexpected command %h %h at %0t with nothing queued in the model",
                command_opcode, command_operand, $time);
            other_errors++;
        end else begin
            popped_entry = expected_entries.pop_front();
            if (command_opcode !== popped_entry[15:8]) begin
                $display("FAIL %0t command_opcode: got %h expected %h",
                    $time, command_opcode, popped_entry[15:8]);
                value_errors++;
            end
            if (command_operand !== popped_entry[7:0]) begin
                $display("FAIL %0t command_operand: got %h expected %h",
                    $time, command_operand, popped_entry[7:0]);
                value_errors++;
            end
        end
    end
end

task automatic wait_cycles(input int count);
    repeat (count) @(posedge clock_18MHz_oscillator);
    #1;
endtask

// Full queue drops the write and sets the sticky flag
function automatic void queue_model_push(input logic [15:0] entry);
    if (expected_entries.size() == graphics_queue_depth) model_overflow = 1'b1;
    else expected_entries.push_back(entry);
endfunction

task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
        spi_data_in = tx[i];
        wait_cycles(spi_half_period);
        spi_clock = 1'b1;
        rx[i] = spi_data_out;                // Host samples on the rising edge
        wait_cycles(spi_half_period);
        spi_clock = 1'b0;
    end
endtask

task automatic run_transaction(input logic [7:0] address, input int data_count);
    logic [7:0] tx;
    logic [7:0] rx;
    rx_bytes.delete();
    spi_select = 1'b0;
    wait_cycles(spi_half_period);
    spi_byte(address, rx);
    for (int i = 0; i < data_count; i++) begin
        tx = $random(random_seed);
        if (address[7:4] == graphics_command_base[7:4]) queue_model_push({address, tx});
        spi_byte(tx, rx);
        rx_bytes.push_back(rx);
    end
    wait_cycles(spi_half_period);
    spi_select = 1'b1;
    wait_cycles(4 * spi_half_period);        // Lets address_valid fall
endtask

task automatic wait_for_drain();
    int guard;
    guard = 0;
    while ((expected_entries.size() != 0 || command_valid) && guard < 200) begin
        wait_cycles(1);
        guard++;
    end
    if (guard == 200) begin
        $display("Command queue did not drain, %0d entries still expected at %0t",
            expected_entries.size(), $time);
        other_errors++;
    end
endtask

initial begin
    logic [7:0] address;
    logic [7:0] status_expected;
    int start_transfers;
    random_seed = 32'h9d4a2315;
    ready_seed = 32'h9d4a2315;
    ready_mode = 0;
    reset = 1'b1;
    spi_select = 1'b1;
    spi_clock = 1'b0;
    spi_data_in = 1'b0;
    command_ready = 1'b0;
    model_overflow = 1'b0;
    transfer_count = 0;
    value_errors = 0;
    other_errors = 0;
    wait_cycles(2);
    reset = 1'b0;

    // Idle outputs after reset
    wait_cycles(4);
    if (command_valid !== 1'b0) begin
        $display("FAIL %0t command_valid: got %b expected 0", $time, command_valid);
        value_errors++;
    end
    if (spi_data_out !== 1'b0) begin
        $display("FAIL %0t spi_data_out: got %b expected 0", $time, spi_data_out);
        value_errors++;
    end

    run_transaction(chip_id_address, 1);
    if (rx_bytes[0] !== chip_id_value) begin
        $display("FAIL %0t spi_data_out chip ID: got %h expected %h",
            $time, rx_bytes[0], chip_id_value);
        value_errors++;
    end

    // Random opcodes with random back-pressure
    ready_mode = 2;
    repeat (24) begin
        address = graphics_command_base | ($random(random_seed) & 8'h0F);
        run_transaction(address, 1 + ($random(random_seed) & 3));
    end
    wait_for_drain();

    // Overflow with the consumer stalled
    ready_mode = 0;
    wait_cycles(2);
    address = graphics_command_base | ($random(random_seed) & 8'h0F);
    run_transaction(address, 9 + ($random(random_seed) & 3));
    status_expected = {model_overflow, 3'b000, 4'(expected_entries.size())};
    run_transaction(graphics_status_address, 1);
    if (rx_bytes[0] !== status_expected) begin
        $display("FAIL %0t spi_data_out status: got %h expected %h",
            $time, rx_bytes[0], status_expected);
        value_errors++;
    end
    start_transfers = transfer_count;
    ready_mode = 1;
    wait_for_drain();
    if (transfer_count - start_transfers != graphics_queue_depth) begin
        $display("Drain after overflow gave %0d entries instead of %0d",
            transfer_count - start_transfers, graphics_queue_depth);
        other_errors++;
    end

    // Unmapped addresses stay silent
    repeat (4) begin
        do begin
            address = $random(random_seed);
        end while (address == chip_id_address || address == graphics_status_address
            || address[7:4] == graphics_command_base[7:4]);
        start_transfers = transfer_count;
        run_transaction(address, 1);
        if (rx_bytes[0] !== 8'h00) begin
            $display("FAIL %0t spi_data_out unmapped %h: got %h expected 00",
                $time, address, rx_bytes[0]);
            value_errors++;
        end
        if (transfer_count != start_transfers || command_valid !== 1'b0) begin
            $display("Unmapped address %h produced a command at %0t", address, $time);
            other_errors++;
        end
    end

    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
        $display("Test passed");
    end else begin
        $display("Test failed");
    end
    $finish;
end

endmodule

/* flist.f */
verilog/frame_pkg.sv
verilog/subperipheral_if.sv
verilog/spi_peripheral.sv
verilog/spi_subperipheral_selector.sv
verilog/spi_register_chip_id.sv
verilog/graphics_command_queue.sv
verilog/frame_top.sv
dv/frame_tb.sv

/* Bender.yml */
package:
  name: frame
  authors: []

sources:
  - files:
      - verilog/frame_pkg.sv
      - verilog/subperipheral_if.sv
      - verilog/spi_peripheral.sv
      - verilog/spi_subperipheral_selector.sv
      - verilog/spi_register_chip_id.sv
      - verilog/graphics_command_queue.sv
      - verilog/frame_top.sv
  - target: test
    files:
      - dv/frame_tb.sv
